// ==== common/laPkg.sv ====
package laPkg;

  // ======================================================================
  // widths
  // ======================================================================
  typedef logic [31:0] wordT;    // data / address word
  typedef logic [4:0]  regIdxT;  // GPR index

  // ======================================================================
  // control encodings
  // ======================================================================
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluPassB   // lu12i.w, operand B straight through
  } aluOpT;

  typedef enum logic [1:0] {
    wbAlu,     // ALU result
    wbMem,     // load data
    wbLink     // pc+4 for bl
  } wbSelT;

  typedef enum logic [1:0] {
    fwdReg,    // regfile / pipeline copy
    fwdEx,
    fwdMem,
    fwdWb
  } fwdSelT;

  typedef enum logic [2:0] {
    brNone,
    brEq,
    brNe,
    brLt,      // signed
    brAlways   // b and bl
  } brTypeT;

  localparam wordT resetPc  = 32'h1C00_0000;
  localparam wordT nopInstr = 32'h0340_0000;  // andi r0, r0, 0

  // ======================================================================
  // opcodes, each matched against the top bits of the word
  // ======================================================================
  // 3R format, instr[31:15]
  localparam logic [16:0] opAddW = 17'h00020;
  localparam logic [16:0] opSubW = 17'h00022;
  localparam logic [16:0] opAnd  = 17'h00029;
  localparam logic [16:0] opOr   = 17'h0002A;
  localparam logic [16:0] opXor  = 17'h0002B;

  // 2RI12 format, instr[31:22]
  localparam logic [9:0] opAddiW = 10'h00A;
  localparam logic [9:0] opAndi  = 10'h00D;
  localparam logic [9:0] opOri   = 10'h00E;
  localparam logic [9:0] opLdW   = 10'h0A2;
  localparam logic [9:0] opStW   = 10'h0A6;

  localparam logic [6:0] opLu12iW = 7'h0A;  // 1RI20, instr[31:25]

  // branches, instr[31:26]
  localparam logic [5:0] opB   = 6'h14;
  localparam logic [5:0] opBl  = 6'h15;
  localparam logic [5:0] opBeq = 6'h16;
  localparam logic [5:0] opBne = 6'h17;
  localparam logic [5:0] opBlt = 6'h18;

endpackage

// ==== decode/branchUnit.sv ====
module branchUnit (
  input  laPkg::wordT   pcD,
  input  laPkg::wordT   imm,        // already shifted offset
  input  laPkg::brTypeT brType,
  input  laPkg::wordT   rdata1,
  input  laPkg::wordT   rdata2,
  input  laPkg::wordT   exResult,   // ALU result, never a load
  input  laPkg::wordT   memResult,  // ALU result or load data
  input  laPkg::fwdSelT fwdC,
  input  laPkg::fwdSelT fwdD,
  output logic          brTaken,
  output laPkg::wordT   brTarget,
  output laPkg::wordT   linkPc
);
  import laPkg::*;

  wordT cmpA, cmpB;

  // WB producers come through the regfile bypass
  function automatic wordT pickSrc(fwdSelT sel, wordT regVal, wordT exVal, wordT memVal);
    case (sel)
      fwdEx:   return exVal;
      fwdMem:  return memVal;
      default: return regVal;
    endcase
  endfunction

  assign cmpA = pickSrc(fwdC, rdata1, exResult, memResult);
  assign cmpB = pickSrc(fwdD, rdata2, exResult, memResult);

  always_comb begin
    case (brType)
      brEq:     brTaken = (cmpA == cmpB);
      brNe:     brTaken = (cmpA != cmpB);
      brLt:     brTaken = ($signed(cmpA) < $signed(cmpB));
      brAlways: brTaken = 1'b1;
      default:  brTaken = 1'b0;
    endcase
  end

  assign brTarget = pcD + imm;
  assign linkPc   = pcD + 32'd4;  // bl return address

endmodule

// ==== decode/decodeCtrl.sv ====
module decodeCtrl (
  input  laPkg::wordT   instrD,
  input  logic          validD,
  output laPkg::regIdxT rs1,
  output laPkg::regIdxT rs2,
  output laPkg::regIdxT rd,
  output laPkg::wordT   imm,
  output laPkg::aluOpT  aluOp,
  output logic          useImm,    // operand B from imm
  output logic          regWrite,
  output logic          memRead,
  output logic          memWrite,
  output laPkg::wbSelT  wbSel,
  output laPkg::brTypeT brType
);
  import laPkg::*;

  logic [16:0] op17;
  logic [9:0]  op10;
  logic [6:0]  op7;
  logic [5:0]  op6;
  wordT        simm12, uimm12, upper20, offs16, offs26;
  logic        useRs1, useRs2, rs2Low;

  assign op17 = instrD[31:15];
  assign op10 = instrD[31:22];
  assign op7  = instrD[31:25];
  assign op6  = instrD[31:26];

  // immediate forms
  assign simm12  = {{20{instrD[21]}}, instrD[21:10]};
  assign uimm12  = {20'b0, instrD[21:10]};                 // andi / ori
  assign upper20 = {instrD[24:5], 12'b0};                  // lu12i.w
  assign offs16  = {{14{instrD[25]}}, instrD[25:10], 2'b00};
  assign offs26  = {{4{instrD[9]}}, instrD[9:0], instrD[25:10], 2'b00};

  always_comb begin
    rd       = instrD[4:0];
    imm      = simm12;
    aluOp    = aluAdd;
    useImm   = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    wbSel    = wbAlu;
    brType   = brNone;
    useRs1   = 1'b0;
    useRs2   = 1'b0;
    rs2Low   = 1'b0;  // rk in [14:10] unless set
    if (!validD) begin
      // bubble, defaults already inert
    end else if (op17 == opAddW || op17 == opSubW || op17 == opAnd ||
                 op17 == opOr || op17 == opXor) begin
      regWrite = 1'b1;
      useRs1   = 1'b1;
      useRs2   = 1'b1;
      case (op17)
        opSubW:  aluOp = aluSub;
        opAnd:   aluOp = aluAnd;
        opOr:    aluOp = aluOr;
        opXor:   aluOp = aluXor;
        default: aluOp = aluAdd;
      endcase
    end else if (op10 == opAddiW || op10 == opLdW) begin
      regWrite = 1'b1;
      useRs1   = 1'b1;
      useImm   = 1'b1;
      memRead  = (op10 == opLdW);               // address = rj + si12
      wbSel    = (op10 == opLdW) ? wbMem : wbAlu;
    end else if (op10 == opAndi || op10 == opOri) begin
      regWrite = 1'b1;
      useRs1   = 1'b1;
      useImm   = 1'b1;
      imm      = uimm12;
      aluOp    = (op10 == opAndi) ? aluAnd : aluOr;
    end else if (op10 == opStW) begin
      memWrite = 1'b1;
      useRs1   = 1'b1;
      useRs2   = 1'b1;  // store data lives in the rd field
      rs2Low   = 1'b1;
      useImm   = 1'b1;
    end else if (op7 == opLu12iW) begin
      regWrite = 1'b1;
      useImm   = 1'b1;
      imm      = upper20;
      aluOp    = aluPassB;
    end else if (op6 == opBeq || op6 == opBne || op6 == opBlt) begin
      useRs1 = 1'b1;
      useRs2 = 1'b1;
      rs2Low = 1'b1;
      imm    = offs16;
      case (op6)
        opBeq:   brType = brEq;
        opBne:   brType = brNe;
        default: brType = brLt;
      endcase
    end else if (op6 == opB || op6 == opBl) begin
      brType = brAlways;
      imm    = offs26;
      if (op6 == opBl) begin
        regWrite = 1'b1;
        rd       = 5'd1;  // link register
        wbSel    = wbLink;
      end
    end
  end

  // unused sources read as r0, so they never forward or stall
  assign rs1 = useRs1 ? instrD[9:5] : '0;
  assign rs2 = !useRs2 ? '0 : rs2Low ? instrD[4:0] : instrD[14:10];

endmodule

// ==== decode/regFile.sv ====
module regFile (
  input  logic          clk,
  input  laPkg::regIdxT rs1,
  input  laPkg::regIdxT rs2,
  output laPkg::wordT   rdata1,
  output laPkg::wordT   rdata2,
  input  logic          we,
  input  laPkg::regIdxT waddr,
  input  laPkg::wordT   wdata
);
  import laPkg::*;

  wordT regs [32];

  always_ff @(posedge clk) begin
    if (we && waddr != '0) regs[waddr] <= wdata;
  end

  // write-through so WB needs no forward path into decode
  assign rdata1 = (rs1 == '0) ? '0 : (we && waddr == rs1) ? wdata : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : (we && waddr == rs2) ? wdata : regs[rs2];

endmodule

// ==== fetch/fetchStage.sv ====
module fetchStage (
  input  logic        clk,
  input  logic        rstN,
  input  logic        stall,     // load hazard, hold everything
  input  logic        brTaken,   // resolved in decode
  input  laPkg::wordT brTarget,
  input  laPkg::wordT instr,
  output laPkg::wordT instrAddr,
  output laPkg::wordT pcD,
  output laPkg::wordT instrD,
  output logic        validD
);
  import laPkg::*;

  wordT pc;

  assign instrAddr = pc;

  // stall beats a taken branch, the branch saw stale operands
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= resetPc;
    end else if (!stall) begin
      pc <= brTaken ? brTarget : pc + 32'd4;  // static not-taken
    end
  end

  // ======================================================================
  // IF/ID register
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      instrD <= nopInstr;
      validD <= 1'b0;
    end else if (!stall) begin
      instrD <= brTaken ? nopInstr : instr;  // squash wrong-path slot
      validD <= !brTaken;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) pcD <= pc;
  end

endmodule

// ==== rtl/executeStage.sv ====
module executeStage (
  input  logic          clk,
  input  logic          rstN,
  input  logic          stall,       // insert bubble
  input  laPkg::regIdxT rs1,
  input  laPkg::regIdxT rs2,
  input  laPkg::regIdxT rd,
  input  laPkg::wordT   rdata1,
  input  laPkg::wordT   rdata2,
  input  laPkg::wordT   imm,
  input  laPkg::aluOpT  aluOp,
  input  logic          useImm,
  input  logic          regWrite,
  input  logic          memRead,
  input  logic          memWrite,
  input  laPkg::wbSelT  wbSel,
  input  laPkg::wordT   pcD,
  input  laPkg::wordT   linkPc,
  input  laPkg::wordT   wbData,      // WB forward
  input  laPkg::wordT   memResult,   // MEM forward
  input  laPkg::fwdSelT fwdA,
  input  laPkg::fwdSelT fwdB,
  output laPkg::wordT   exResult,
  output laPkg::wordT   storeData,
  output laPkg::regIdxT rdE,
  output laPkg::regIdxT rs1E,
  output laPkg::regIdxT rs2E,
  output logic          regWriteE,
  output logic          memReadE,
  output logic          memWriteE,
  output laPkg::wbSelT  wbSelE,
  output laPkg::wordT   pcE,
  output laPkg::wordT   linkPcE
);
  import laPkg::*;

  wordT  rdata1E, rdata2E, immE;
  aluOpT aluOpE;
  logic  useImmE;
  wordT  srcA, srcB, aluY;

  // ======================================================================
  // ID/EX register
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!rstN || stall) begin
      regWriteE <= 1'b0;
      memReadE  <= 1'b0;
      memWriteE <= 1'b0;
    end else begin
      regWriteE <= regWrite;
      memReadE  <= memRead;
      memWriteE <= memWrite;
    end
  end

  always_ff @(posedge clk) begin
    rs1E    <= rs1;
    rs2E    <= rs2;
    rdE     <= rd;
    rdata1E <= rdata1;
    rdata2E <= rdata2;
    immE    <= imm;
    aluOpE  <= aluOp;
    useImmE <= useImm;
    wbSelE  <= wbSel;
    pcE     <= pcD;
    linkPcE <= linkPc;
  end

  // ======================================================================
  // operands and ALU
  // ======================================================================
  function automatic wordT fwdMux(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
    case (sel)
      fwdMem:  return memVal;
      fwdWb:   return wbVal;
      default: return regVal;
    endcase
  endfunction

  assign srcA      = fwdMux(fwdA, rdata1E, memResult, wbData);
  assign storeData = fwdMux(fwdB, rdata2E, memResult, wbData);  // st.w data
  assign srcB      = useImmE ? immE : storeData;

  always_comb begin
    case (aluOpE)
      aluSub:   aluY = srcA - srcB;
      aluAnd:   aluY = srcA & srcB;
      aluOr:    aluY = srcA | srcB;
      aluXor:   aluY = srcA ^ srcB;
      aluPassB: aluY = srcB;
      default:  aluY = srcA + srcB;  // add, addresses
    endcase
  end

  assign exResult = aluY;

endmodule

// ==== rtl/hazardUnit.sv ====
module hazardUnit (
  input  laPkg::regIdxT rs1,        // decode sources
  input  laPkg::regIdxT rs2,
  input  laPkg::regIdxT rs1E,
  input  laPkg::regIdxT rs2E,
  input  laPkg::regIdxT rdE,
  input  laPkg::regIdxT rdM,
  input  laPkg::regIdxT rdW,
  input  logic          regWriteE,
  input  logic          memReadE,
  input  logic          regWriteM,
  input  logic          memReadM,
  input  logic          regWriteW,
  input  laPkg::brTypeT brType,
  output logic          stall,
  output laPkg::fwdSelT fwdA,
  output laPkg::fwdSelT fwdB,
  output laPkg::fwdSelT fwdC,
  output laPkg::fwdSelT fwdD
);
  import laPkg::*;

  logic isBranch, aluE, writesM;

  // EX consumer, MEM beats WB
  function automatic fwdSelT exSel(regIdxT src, regIdxT dstM, logic wrM,
                                   regIdxT dstW, logic wrW);
    if (src == '0) return fwdReg;
    if (wrM && dstM == src) return fwdMem;
    if (wrW && dstW == src) return fwdWb;
    return fwdReg;
  endfunction

  // compare operand in decode, EX beats MEM
  function automatic fwdSelT idSel(logic en, regIdxT src, regIdxT dstE, logic wrE,
                                   regIdxT dstM, logic wrM);
    if (!en || src == '0) return fwdReg;
    if (wrE && dstE == src) return fwdEx;
    if (wrM && dstM == src) return fwdMem;
    return fwdReg;
  endfunction

  assign isBranch = (brType == brEq) || (brType == brNe) || (brType == brLt);
  assign aluE     = regWriteE && !memReadE;      // load in EX stalls instead
  assign writesM  = regWriteM || memReadM;       // load data via dataRdata

  assign fwdA = exSel(rs1E, rdM, writesM, rdW, regWriteW);
  assign fwdB = exSel(rs2E, rdM, writesM, rdW, regWriteW);
  assign fwdC = idSel(isBranch, rs1, rdE, aluE, rdM, writesM);
  assign fwdD = idSel(isBranch, rs2, rdE, aluE, rdM, writesM);

  // load in EX feeding decode, ALU use or branch compare alike
  assign stall = memReadE && rdE != '0 && (rdE == rs1 || rdE == rs2);

endmodule

// ==== rtl/laCore.sv ====
module laCore (
  input  logic          clk,
  input  logic          rstN,
  output laPkg::wordT   instrAddr,  // fetch pc
  input  laPkg::wordT   instr,      // same-cycle instruction word
  output laPkg::wordT   dataAddr,
  output laPkg::wordT   dataWdata,
  output logic          dataWe,
  input  laPkg::wordT   dataRdata,
  output logic          wbWe,       // debug, one pulse per register write
  output laPkg::wordT   wbPc,
  output laPkg::regIdxT wbReg,
  output laPkg::wordT   wbData
);
  import laPkg::*;

  // IF/ID
  wordT   pcD, instrD;
  logic   validD;
  // decode
  regIdxT rs1, rs2, rd;
  wordT   imm, rdata1, rdata2;
  aluOpT  aluOp;
  logic   useImm, regWrite, memRead, memWrite;
  wbSelT  wbSel;
  brTypeT brType;
  logic   brTaken;
  wordT   brTarget, linkPc;
  // execute
  wordT   exResult, storeData, pcE, linkPcE;
  regIdxT rdE, rs1E, rs2E;
  logic   regWriteE, memReadE, memWriteE;
  wbSelT  wbSelE;
  // mem / wb
  wordT   memResult;
  regIdxT rdM;
  logic   regWriteM, memReadM, regWriteW;
  // hazards
  logic   stall;
  fwdSelT fwdA, fwdB, fwdC, fwdD;

  fetchStage u_fetchStage (
    .clk(clk), .rstN(rstN), .stall(stall), .brTaken(brTaken),
    .brTarget(brTarget), .instr(instr), .instrAddr(instrAddr),
    .pcD(pcD), .instrD(instrD), .validD(validD)
  );

  decodeCtrl u_decodeCtrl (
    .instrD(instrD), .validD(validD), .rs1(rs1), .rs2(rs2), .rd(rd),
    .imm(imm), .aluOp(aluOp), .useImm(useImm), .regWrite(regWrite),
    .memRead(memRead), .memWrite(memWrite), .wbSel(wbSel), .brType(brType)
  );

  // written from WB, read in decode
  regFile u_regFile (
    .clk(clk), .rs1(rs1), .rs2(rs2), .rdata1(rdata1), .rdata2(rdata2),
    .we(regWriteW), .waddr(wbReg), .wdata(wbData)
  );

  branchUnit u_branchUnit (
    .pcD(pcD), .imm(imm), .brType(brType), .rdata1(rdata1), .rdata2(rdata2),
    .exResult(exResult), .memResult(memResult), .fwdC(fwdC), .fwdD(fwdD),
    .brTaken(brTaken), .brTarget(brTarget), .linkPc(linkPc)
  );

  executeStage u_executeStage (
    .clk(clk), .rstN(rstN), .stall(stall),
    .rs1(rs1), .rs2(rs2), .rd(rd), .rdata1(rdata1), .rdata2(rdata2),
    .imm(imm), .aluOp(aluOp), .useImm(useImm), .regWrite(regWrite),
    .memRead(memRead), .memWrite(memWrite), .wbSel(wbSel),
    .pcD(pcD), .linkPc(linkPc), .wbData(wbData), .memResult(memResult),
    .fwdA(fwdA), .fwdB(fwdB), .exResult(exResult), .storeData(storeData),
    .rdE(rdE), .rs1E(rs1E), .rs2E(rs2E), .regWriteE(regWriteE),
    .memReadE(memReadE), .memWriteE(memWriteE), .wbSelE(wbSelE),
    .pcE(pcE), .linkPcE(linkPcE)
  );

  hazardUnit u_hazardUnit (
    .rs1(rs1), .rs2(rs2), .rs1E(rs1E), .rs2E(rs2E),
    .rdE(rdE), .rdM(rdM), .rdW(wbReg),
    .regWriteE(regWriteE), .memReadE(memReadE), .regWriteM(regWriteM),
    .memReadM(memReadM), .regWriteW(regWriteW), .brType(brType),
    .stall(stall), .fwdA(fwdA), .fwdB(fwdB), .fwdC(fwdC), .fwdD(fwdD)
  );

  memWbStage u_memWbStage (
    .clk(clk), .rstN(rstN),
    .exResult(exResult), .storeData(storeData), .rdE(rdE),
    .regWriteE(regWriteE), .memReadE(memReadE), .memWriteE(memWriteE),
    .wbSelE(wbSelE), .pcE(pcE), .linkPcE(linkPcE),
    .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe),
    .dataRdata(dataRdata), .memResult(memResult), .rdM(rdM),
    .regWriteM(regWriteM), .memReadM(memReadM), .regWriteW(regWriteW),
    .wbWe(wbWe), .wbPc(wbPc), .wbReg(wbReg), .wbData(wbData)
  );

endmodule

// ==== rtl/memWbStage.sv ====
module memWbStage (
  input  logic          clk,
  input  logic          rstN,
  input  laPkg::wordT   exResult,
  input  laPkg::wordT   storeData,
  input  laPkg::regIdxT rdE,
  input  logic          regWriteE,
  input  logic          memReadE,
  input  logic          memWriteE,
  input  laPkg::wbSelT  wbSelE,
  input  laPkg::wordT   pcE,
  input  laPkg::wordT   linkPcE,
  output laPkg::wordT   dataAddr,
  output laPkg::wordT   dataWdata,
  output logic          dataWe,
  input  laPkg::wordT   dataRdata,   // combinational read
  output laPkg::wordT   memResult,
  output laPkg::regIdxT rdM,
  output logic          regWriteM,
  output logic          memReadM,
  output logic          regWriteW,
  output logic          wbWe,
  output laPkg::wordT   wbPc,
  output laPkg::regIdxT wbReg,
  output laPkg::wordT   wbData
);
  import laPkg::*;

  wordT  resultM, pcM, linkPcM;
  wbSelT wbSelM;
  wordT  resultW, loadW, linkPcW;
  wbSelT wbSelW;

  // ======================================================================
  // EX/MEM
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memReadM  <= 1'b0;
      dataWe    <= 1'b0;
    end else begin
      regWriteM <= regWriteE;
      memReadM  <= memReadE;
      dataWe    <= memWriteE;  // single-cycle store strobe
    end
  end

  always_ff @(posedge clk) begin
    resultM   <= exResult;
    dataWdata <= storeData;
    rdM       <= rdE;
    wbSelM    <= wbSelE;
    pcM       <= pcE;
    linkPcM   <= linkPcE;
  end

  assign dataAddr  = resultM;
  // load data, bl return address or ALU result
  assign memResult = memReadM ? dataRdata : (wbSelM == wbLink) ? linkPcM : resultM;

  // ======================================================================
  // MEM/WB
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!rstN) regWriteW <= 1'b0;
    else       regWriteW <= regWriteM;
  end

  always_ff @(posedge clk) begin
    resultW <= resultM;
    loadW   <= dataRdata;
    wbReg   <= rdM;
    wbSelW  <= wbSelM;
    wbPc    <= pcM;
    linkPcW <= linkPcM;
  end

  always_comb begin
    case (wbSelW)
      wbMem:   wbData = loadW;
      wbLink:  wbData = linkPcW;
      default: wbData = resultW;
    endcase
  end

  assign wbWe = regWriteW && wbReg != '0;  // r0 writes stay silent

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module laCoreTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/VlaCoreTb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi
exit 0

// ==== tb.f ====
+incdir+tests
common/laPkg.sv
fetch/fetchStage.sv
decode/decodeCtrl.sv
decode/regFile.sv
decode/branchUnit.sv
rtl/executeStage.sv
rtl/hazardUnit.sv
rtl/memWbStage.sv
rtl/laCore.sv
tests/laCoreTb.sv

// ==== tests/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ======================================================================
// table builder with an ISA-level model of each instruction
// ======================================================================
// each builder appends one word to the ROM and, unless it sits in the
// shadow of a taken branch, its architectural effect to the expected table

task automatic put(input wordT word);
  rom[nInstr[9:0]] = word;
  nInstr++;
endtask

task automatic expectWb(input string name, input int rd, input wordT value);
  wordT pc;
  pc = resetPc + nInstr * 4;  // pc of the word about to be placed
  if (!skipping && rd != 0) begin
    expEv.push_back({1'b0, pc, rd[4:0], value});
    expName.push_back(name);
    mreg[rd[4:0]] = value;
  end
endtask

task automatic expectSt(input string name, input wordT addr, input wordT data);
  if (!skipping) begin
    expEv.push_back({1'b1, addr, 5'd0, data});
    expName.push_back(name);
    mram[addr[9:2]] = data;
  end
endtask

task automatic aluR(input string name, input logic [16:0] op, input int rd,
                    input int rj, input int rk);
  wordT a, b, y;
  a = mreg[rj[4:0]];
  b = mreg[rk[4:0]];
  case (op)
    opSubW:  y = a - b;
    opAnd:   y = a & b;
    opOr:    y = a | b;
    opXor:   y = a ^ b;
    default: y = a + b;
  endcase
  expectWb(name, rd, y);
  put({op, rk[4:0], rj[4:0], rd[4:0]});
endtask

task automatic aluI(input string name, input logic [9:0] op, input int rd,
                    input int rj, input int imm);
  logic [11:0] i12;
  wordT        a, y;
  i12 = imm[11:0];
  a   = mreg[rj[4:0]];
  case (op)
    opAndi:  y = a & {20'b0, i12};            // zero-extended
    opOri:   y = a | {20'b0, i12};
    default: y = a + {{20{i12[11]}}, i12};    // addi.w sign-extends
  endcase
  expectWb(name, rd, y);
  put({op, i12, rj[4:0], rd[4:0]});
endtask

task automatic lu12i(input string name, input int rd, input int imm);
  expectWb(name, rd, {imm[19:0], 12'b0});
  put({opLu12iW, imm[19:0], rd[4:0]});
endtask

task automatic ldw(input string name, input int rd, input int rj, input int off);
  wordT addr;
  addr = mreg[rj[4:0]] + {{20{off[11]}}, off[11:0]};
  expectWb(name, rd, mram[addr[9:2]]);
  put({opLdW, off[11:0], rj[4:0], rd[4:0]});
endtask

task automatic stw(input string name, input int rd, input int rj, input int off);
  wordT addr;
  addr = mreg[rj[4:0]] + {{20{off[11]}}, off[11:0]};
  expectSt(name, addr, mreg[rd[4:0]]);   // data register sits in rd
  put({opStW, off[11:0], rj[4:0], rd[4:0]});
endtask

// fall-through slot that only counts when the branch before it is not taken
task automatic shadow(input bit taken);
  skipping = taken;
  aluI("shadow addi.w r30", opAddiW, 30, 0, 32'h100 + nInstr);
  skipping = 1'b0;
endtask

// conditional branch over one word comparing rj with rd
task automatic branch(input logic [5:0] op, input int rj, input int rd);
  wordT a, b;
  bit   taken;
  a = mreg[rj[4:0]];
  b = mreg[rd[4:0]];
  case (op)
    opBeq:   taken = (a == b);
    opBne:   taken = (a != b);
    default: taken = ($signed(a) < $signed(b));
  endcase
  put({op, 16'd2, rj[4:0], rd[4:0]});  // target pc+8
  shadow(taken);
endtask

task automatic jump(input string name, input bit link);
  if (link) expectWb(name, 1, resetPc + nInstr * 4 + 4);  // return address
  put({link ? opBl : opB, 16'd2, 10'd0});
  shadow(1'b1);
endtask

// ======================================================================
// the program
// ======================================================================
task automatic buildProgram();
  // random seeds
  lu12i("lu12i.w r2", 2, randBits(20));
  aluI("ori r2", opOri, 2, 2, randBits(12));       // MEM forward
  lu12i("lu12i.w r3", 3, randBits(20));
  aluI("addi.w r3", opAddiW, 3, 3, randBits(12));
  aluI("addi.w r4", opAddiW, 4, 0, randBits(12));
  // dependency chain through EX/MEM/WB forwarding
  aluR("add.w r5", opAddW, 5, 2, 3);
  aluR("sub.w r6", opSubW, 6, 5, 4);
  aluR("and r7", opAnd, 7, 6, 2);
  aluR("or r8", opOr, 8, 7, 6);
  aluR("xor r9", opXor, 9, 8, 5);
  aluI("andi r10", opAndi, 10, 9, randBits(12));
  aluR("add.w r0", opAddW, 0, 9, 9);               // silent
  aluR("add.w r11", opAddW, 11, 0, 9);             // r0 reads zero
  // store then load
  aluI("addi.w r12", opAddiW, 12, 0, 32'h40);      // data base
  stw("st.w r9", 9, 12, 32'h8);
  ldw("ld.w r13", 13, 12, 32'h8);
  aluR("add.w r14", opAddW, 14, 13, 2);            // load-use stall
  stw("st.w r14", 14, 12, 32'hc);                  // store data forward
  ldw("ld.w r15", 15, 12, 32'h4);                  // fill word
  // branches
  aluR("add.w r16", opAddW, 16, 13, 0);            // copy of r9
  branch(opBeq, 16, 9);                            // taken via EX forward
  ldw("ld.w r17", 17, 12, 32'hc);
  branch(opBne, 17, 14);                           // not taken with the load in EX
  branch(opBeq, 2, 3);
  ldw("ld.w r18", 18, 12, 32'h8);
  aluI("addi.w r19", opAddiW, 19, 9, 0);           // copy of r9
  branch(opBne, 18, 19);                           // not taken with load in MEM and ALU in EX
  aluI("addi.w r21", opAddiW, 21, 0, 32'hfff);     // -1
  branch(opBlt, 21, 0);                            // taken
  branch(opBlt, 0, 21);                            // not taken
  branch(opBlt, 4, 2);
  jump("b", 1'b0);
  jump("bl r1", 1'b1);
  aluR("add.w r22", opAddW, 22, 1, 15);
endtask

`endif

// ==== tests/laCoreTb.sv ====
module laCoreTb;
  import laPkg::*;

  typedef logic [69:0] eventT;  // {isStore, pc or addr, reg, value}

  logic   clk = 1'b0;
  logic   rstN;
  wordT   instrAddr, instr;
  wordT   dataAddr, dataWdata, dataRdata;
  logic   dataWe, wbWe;
  wordT   wbPc, wbData;
  regIdxT wbReg;

  wordT   rom [1024];    // instruction ROM
  wordT   ram [256];     // data RAM, word addressed
  wordT   mreg [32];     // model register file
  wordT   mram [256];    // model data memory
  int     nInstr = 0;
  bit     skipping = 1'b0;
  wordT   lfsrState;
  eventT  expEv[$];
  string  expName[$];
  eventT  events[$];     // observed, in order

  laCore u_laCore (
    .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
    .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe),
    .dataRdata(dataRdata), .wbWe(wbWe), .wbPc(wbPc), .wbReg(wbReg),
    .wbData(wbData)
  );

  always #4 clk = ~clk;

  // ======================================================================
  // random source and memory fill
  // ======================================================================
  function automatic wordT lfsrStep(wordT s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois taps
  endfunction

  function automatic wordT randBits(int n);
    wordT v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v         = {v[30:0], lfsrState[0]};
      lfsrState = lfsrStep(lfsrState);  // one step per bit
    end
    return v;
  endfunction

  function automatic wordT fillWord(logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5a, 8'h3c + idx};
  endfunction

  `include "tbProgram.svh"

  // memories answer in the same cycle
  assign instr     = rom[instrAddr[11:2]];
  assign dataRdata = ram[dataAddr[9:2]];

  always @(posedge clk) begin
    if (dataWe) ram[dataAddr[9:2]] <= dataWdata;
  end

  // sampled mid-cycle, older instruction's write first
  always @(negedge clk) begin
    if (rstN && wbWe) events.push_back({1'b0, wbPc, wbReg, wbData});
    if (rstN && dataWe) events.push_back({1'b1, dataAddr, 5'd0, dataWdata});
  end

  // ======================================================================
  // checking
  // ======================================================================
  function automatic string describe(eventT ev);
    if (ev[69]) return $sformatf("store addr=%h data=%h", ev[68:37], ev[31:0]);
    return $sformatf("write pc=%h r%0d=%h", ev[68:37], ev[36:32], ev[31:0]);
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic waitForEvent(input string name);
    int cycles;
    cycles = 0;
    while (events.size() == 0 && cycles < 100) begin
      @(posedge clk);
      cycles++;
    end
    if (events.size() == 0) failRun({"timed out waiting for ", name});
  endtask

  initial begin
    eventT got;
    int    idle;
    rstN      = 1'b0;
    lfsrState = 32'h63af;
    for (int i = 0; i < 1024; i++) rom[i[9:0]] = nopInstr;  // tail of bubbles
    for (int i = 0; i < 256; i++) begin
      ram[i[7:0]]  = fillWord(i[7:0]);
      mram[i[7:0]] = fillWord(i[7:0]);
    end
    for (int i = 0; i < 32; i++) mreg[i[4:0]] = '0;
    buildProgram();

    for (int i = 0; i < 3; i++) @(posedge clk);  // reset cycles
    rstN <= 1'b1;

    for (int i = 0; i < expEv.size(); i++) begin
      waitForEvent(expName[i]);
      got = events.pop_front();
      assert (got == expEv[i]) else
        failRun($sformatf("CHECK FAILED %s: expected %s, actual %s",
                          expName[i], describe(expEv[i]), describe(got)));
    end

    // nothing more may write once the table is done
    idle = 0;
    while (events.size() == 0 && idle < 20) begin
      @(posedge clk);
      idle++;
    end
    if (events.size() == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      failRun({"unexpected event after the last entry, ", describe(events[0])});
    end
  end

endmodule
